// File: src/tpu_macros.svh
`ifndef TPU_MACROS_SVH
`define TPU_MACROS_SVH

// array side, the grid is TPU_DIM x TPU_DIM cells
`define TPU_DIM 4

`define TPU_OP_W 8    // unsigned operand
`define TPU_ACC_W 32  // per-cell accumulator

`define TPU_IDX_W 16  // memory index
`define TPU_SIZE_W 8  // K, M and N

// memory read, feeder register, lane skew and the hops to the far corner cell
`define TPU_SETTLE (2 * `TPU_DIM + 1)

`endif

// File: src/tpu_cfg_pkg.sv
`default_nettype none

`include "tpu_macros.svh"

package tpu_cfg_pkg;

    typedef logic [`TPU_SIZE_W-1:0] dim_t;  // one matrix dimension
    typedef logic [`TPU_IDX_W-1:0] idx_t;   // A, B or C word index

    typedef logic [`TPU_DIM-1:0] lane_mask_t;  // one bit per array lane

    // per-tile control handed from the sequencer to the feeder and the drain
    typedef struct packed {
        lane_mask_t row_mask;  // rows of the tile that fall inside M
        lane_mask_t col_mask;  // columns of the tile that fall inside N
        idx_t       c_base;    // C index of row 0 of the tile
    } tile_info_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FEED,
        SEQ_SETTLE,
        SEQ_DRAIN
    } seq_state_t;

endpackage

`default_nettype wire

// File: src/tpu_data_pkg.sv
`default_nettype none

`include "tpu_macros.svh"

package tpu_data_pkg;

    typedef logic [`TPU_OP_W-1:0] operand_t;
    typedef logic [`TPU_ACC_W-1:0] acc_t;

    // one A or B memory word, lane r in byte r
    typedef operand_t [`TPU_DIM-1:0] lane_vec_t;

    // one C word, column c in bits 32c upward
    typedef acc_t [`TPU_DIM-1:0] c_row_t;

    // all accumulators of the grid, row first then column
    typedef c_row_t [`TPU_DIM-1:0] acc_grid_t;

endpackage

`default_nettype wire

// File: src/pe_cell.sv
`timescale 1ns/10ps
`default_nettype none

module pe_cell (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tile_start,
    input  tpu_data_pkg::operand_t  west,
    input  tpu_data_pkg::operand_t  north,
    output tpu_data_pkg::operand_t  east,
    output tpu_data_pkg::operand_t  south,
    output tpu_data_pkg::acc_t      acc
);

    tpu_data_pkg::acc_t product;

    assign product = tpu_data_pkg::acc_t'(west) * tpu_data_pkg::acc_t'(north);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            east  <= '0;
            south <= '0;
            acc   <= '0;
        end else begin
            east  <= west;   // one hop east
            south <= north;  // one hop south
            if (tile_start) begin
                acc <= '0;
            end else begin
                acc <= acc + product;  // zero lanes add nothing
            end
        end
    end

endmodule

`default_nettype wire

// File: src/operand_feeder.sv
`timescale 1ns/10ps
`default_nettype none

`include "tpu_macros.svh"

module operand_feeder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     feed_valid,
    input  tpu_cfg_pkg::tile_info_t  tile_info,
    input  tpu_data_pkg::lane_vec_t  a_data,
    input  tpu_data_pkg::lane_vec_t  b_data,
    output tpu_data_pkg::lane_vec_t  west_edge,
    output tpu_data_pkg::lane_vec_t  north_edge
);

    // side 0 carries A rows to the west edge, side 1 carries B columns to the north edge
    logic fed_q;  // feed_valid aligned with the returning memory word

    tpu_data_pkg::lane_vec_t raw [2];
    tpu_cfg_pkg::lane_mask_t mask [2];
    tpu_data_pkg::lane_vec_t stage [2][`TPU_DIM];  // stage s holds every lane delayed s more

    assign raw[0]  = a_data;
    assign raw[1]  = b_data;
    assign mask[0] = tile_info.row_mask;
    assign mask[1] = tile_info.col_mask;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fed_q <= 1'b0;
            for (int side = 0; side < 2; side++) begin
                for (int s = 0; s < `TPU_DIM; s++) begin
                    stage[side][s] <= '0;
                end
            end
        end else begin
            fed_q <= feed_valid;
            for (int side = 0; side < 2; side++) begin
                for (int r = 0; r < `TPU_DIM; r++) begin
                    stage[side][0][r] <= (fed_q && mask[side][r]) ? raw[side][r] : '0;
                end
                for (int s = 1; s < `TPU_DIM; s++) begin
                    stage[side][s] <= stage[side][s-1];
                end
            end
        end
    end

    // lane r leaves after r skew stages
    for (genvar r = 0; r < `TPU_DIM; r++) begin : g_lane
        assign west_edge[r]  = stage[0][r][r];
        assign north_edge[r] = stage[1][r][r];
    end

endmodule

`default_nettype wire

// File: src/result_drain.sv
`timescale 1ns/10ps
`default_nettype none

`include "tpu_macros.svh"

module result_drain (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     tile_done,
    input  tpu_cfg_pkg::tile_info_t  tile_info,
    input  tpu_data_pkg::acc_grid_t  acc_grid,
    output logic                     c_wr_en,
    output tpu_cfg_pkg::idx_t        c_index,
    output tpu_data_pkg::c_row_t     c_data,
    output logic                     drain_done
);

    localparam int ROW_W = $clog2(`TPU_DIM);

    logic                    active_q;
    logic [ROW_W-1:0]        row_q;
    tpu_cfg_pkg::lane_mask_t mask_q;
    tpu_cfg_pkg::idx_t       base_q;

    logic                    issue;
    logic                    last_row;
    logic [ROW_W-1:0]        cur_row;
    tpu_cfg_pkg::lane_mask_t cur_mask;
    tpu_cfg_pkg::idx_t       cur_base;

    // row 0 goes out on tile_done itself, the rest from the latched copy
    assign issue    = tile_done || active_q;
    assign cur_row  = tile_done ? '0 : row_q;
    assign cur_mask = tile_done ? tile_info.row_mask : mask_q;
    assign cur_base = tile_done ? tile_info.c_base : base_q;

    // valid rows form a prefix of the tile, so the first clear bit ends it
    assign last_row = (cur_row == ROW_W'(`TPU_DIM - 1)) || !cur_mask[cur_row + 1'b1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q   <= 1'b0;
            row_q      <= '0;
            c_wr_en    <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            c_wr_en    <= issue;
            drain_done <= issue && last_row;
            if (issue) begin
                active_q <= !last_row;
                row_q    <= cur_row + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile_done) begin
            mask_q <= tile_info.row_mask;
            base_q <= tile_info.c_base;
        end
        if (issue) begin
            c_index <= cur_base + tpu_cfg_pkg::idx_t'(cur_row);
            c_data  <= acc_grid[cur_row];
        end
    end

endmodule

`default_nettype wire

// File: src/tile_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "tpu_macros.svh"

module tile_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  tpu_cfg_pkg::dim_t        k_dim,
    input  tpu_cfg_pkg::dim_t        m_dim,
    input  tpu_cfg_pkg::dim_t        n_dim,
    input  logic                     drain_done,
    output logic                     busy,
    output tpu_cfg_pkg::idx_t        a_index,
    output tpu_cfg_pkg::idx_t        b_index,
    output logic                     feed_valid,
    output logic                     tile_start,
    output logic                     tile_done,
    output tpu_cfg_pkg::tile_info_t  tile_info
);

    localparam int SETTLE_W = $clog2(`TPU_SETTLE + 1);

    tpu_cfg_pkg::seq_state_t state_q;

    tpu_cfg_pkg::dim_t k_q;
    tpu_cfg_pkg::dim_t m_q;
    tpu_cfg_pkg::dim_t n_q;

    tpu_cfg_pkg::dim_t k_cnt;
    tpu_cfg_pkg::dim_t mb_q;  // row block, inner loop
    tpu_cfg_pkg::dim_t nb_q;  // column block, outer loop
    logic [SETTLE_W-1:0] settle_cnt;

    tpu_cfg_pkg::idx_t a_base_q;  // mb * K
    tpu_cfg_pkg::idx_t b_base_q;  // nb * K
    tpu_cfg_pkg::idx_t c_col_q;   // nb * M

    tpu_cfg_pkg::idx_t row_first;
    tpu_cfg_pkg::idx_t col_first;

    logic accept;
    logic last_mb;
    logic last_nb;

    assign accept = in_valid && (state_q == tpu_cfg_pkg::SEQ_IDLE) &&
                    (k_dim != '0) && (m_dim != '0) && (n_dim != '0);

    assign row_first = tpu_cfg_pkg::idx_t'(mb_q) << 2;
    assign col_first = tpu_cfg_pkg::idx_t'(nb_q) << 2;

    assign last_mb = (row_first + tpu_cfg_pkg::idx_t'(`TPU_DIM)) >= tpu_cfg_pkg::idx_t'(m_q);
    assign last_nb = (col_first + tpu_cfg_pkg::idx_t'(`TPU_DIM)) >= tpu_cfg_pkg::idx_t'(n_q);

    always_comb begin
        for (int r = 0; r < `TPU_DIM; r++) begin
            tile_info.row_mask[r] = (row_first + tpu_cfg_pkg::idx_t'(r)) <
                                    tpu_cfg_pkg::idx_t'(m_q);
            tile_info.col_mask[r] = (col_first + tpu_cfg_pkg::idx_t'(r)) <
                                    tpu_cfg_pkg::idx_t'(n_q);
        end
        tile_info.c_base = c_col_q + row_first;
    end

    assign busy = (state_q != tpu_cfg_pkg::SEQ_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= tpu_cfg_pkg::SEQ_IDLE;
            tile_start <= 1'b0;
            tile_done  <= 1'b0;
            feed_valid <= 1'b0;
            k_cnt      <= '0;
            settle_cnt <= '0;
            mb_q       <= '0;
            nb_q       <= '0;
            a_base_q   <= '0;
            b_base_q   <= '0;
            c_col_q    <= '0;
        end else begin
            tile_start <= 1'b0;
            tile_done  <= 1'b0;
            feed_valid <= 1'b0;
            case (state_q)
                tpu_cfg_pkg::SEQ_IDLE: begin
                    if (accept) begin
                        tile_start <= 1'b1;
                        state_q    <= tpu_cfg_pkg::SEQ_FEED;
                        k_cnt      <= '0;
                        mb_q       <= '0;
                        nb_q       <= '0;
                        a_base_q   <= '0;
                        b_base_q   <= '0;
                        c_col_q    <= '0;
                    end
                end
                tpu_cfg_pkg::SEQ_FEED: begin
                    feed_valid <= 1'b1;  // index for step k_cnt goes out next cycle
                    k_cnt      <= k_cnt + 1'b1;
                    if (k_cnt == k_q - 1'b1) begin
                        settle_cnt <= '0;
                        state_q    <= tpu_cfg_pkg::SEQ_SETTLE;
                    end
                end
                tpu_cfg_pkg::SEQ_SETTLE: begin
                    settle_cnt <= settle_cnt + 1'b1;
                    if (settle_cnt == SETTLE_W'(`TPU_SETTLE - 1)) begin
                        tile_done <= 1'b1;
                        state_q   <= tpu_cfg_pkg::SEQ_DRAIN;
                    end
                end
                default: begin
                    if (drain_done) begin
                        if (last_mb && last_nb) begin
                            state_q <= tpu_cfg_pkg::SEQ_IDLE;
                        end else begin
                            tile_start <= 1'b1;
                            state_q    <= tpu_cfg_pkg::SEQ_FEED;
                            k_cnt      <= '0;
                            if (!last_mb) begin
                                mb_q     <= mb_q + 1'b1;
                                a_base_q <= a_base_q + tpu_cfg_pkg::idx_t'(k_q);
                            end else begin  // wrap to the next column block
                                mb_q     <= '0;
                                a_base_q <= '0;
                                nb_q     <= nb_q + 1'b1;
                                b_base_q <= b_base_q + tpu_cfg_pkg::idx_t'(k_q);
                                c_col_q  <= c_col_q + tpu_cfg_pkg::idx_t'(m_q);
                            end
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            k_q <= k_dim;
            m_q <= m_dim;
            n_q <= n_dim;
        end
        if (state_q == tpu_cfg_pkg::SEQ_FEED) begin
            a_index <= a_base_q + tpu_cfg_pkg::idx_t'(k_cnt);
            b_index <= b_base_q + tpu_cfg_pkg::idx_t'(k_cnt);
        end
    end

endmodule

`default_nettype wire

// File: src/tpu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "tpu_macros.svh"

module tpu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  tpu_cfg_pkg::dim_t        k_dim,
    input  tpu_cfg_pkg::dim_t        m_dim,
    input  tpu_cfg_pkg::dim_t        n_dim,
    output logic                     busy,
    output tpu_cfg_pkg::idx_t        a_index,
    input  tpu_data_pkg::lane_vec_t  a_data,
    output tpu_cfg_pkg::idx_t        b_index,
    input  tpu_data_pkg::lane_vec_t  b_data,
    output logic                     c_wr_en,
    output tpu_cfg_pkg::idx_t        c_index,
    output tpu_data_pkg::c_row_t     c_data
);

    wire                          feed_valid;
    wire                          tile_start;
    wire                          tile_done;
    wire                          drain_done;
    wire tpu_cfg_pkg::tile_info_t tile_info;
    wire tpu_data_pkg::lane_vec_t west_edge;
    wire tpu_data_pkg::lane_vec_t north_edge;
    wire tpu_data_pkg::acc_grid_t acc_grid;

    // h_link[i][j] enters cell (i, j) from the west, v_link[i][j] from the north
    wire tpu_data_pkg::operand_t h_link [`TPU_DIM][`TPU_DIM+1];
    wire tpu_data_pkg::operand_t v_link [`TPU_DIM+1][`TPU_DIM];

    tile_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .k_dim      (k_dim),
        .m_dim      (m_dim),
        .n_dim      (n_dim),
        .drain_done (drain_done),
        .busy       (busy),
        .a_index    (a_index),
        .b_index    (b_index),
        .feed_valid (feed_valid),
        .tile_start (tile_start),
        .tile_done  (tile_done),
        .tile_info  (tile_info)
    );

    operand_feeder u_feeder (
        .clk        (clk),
        .rst_n      (rst_n),
        .feed_valid (feed_valid),
        .tile_info  (tile_info),
        .a_data     (a_data),
        .b_data     (b_data),
        .west_edge  (west_edge),
        .north_edge (north_edge)
    );

    for (genvar i = 0; i < `TPU_DIM; i++) begin : g_row
        assign h_link[i][0] = west_edge[i];
        assign v_link[0][i] = north_edge[i];
        for (genvar j = 0; j < `TPU_DIM; j++) begin : g_col
            pe_cell u_cell (
                .clk        (clk),
                .rst_n      (rst_n),
                .tile_start (tile_start),
                .west       (h_link[i][j]),
                .north      (v_link[i][j]),
                .east       (h_link[i][j+1]),
                .south      (v_link[i+1][j]),
                .acc        (acc_grid[i][j])
            );
        end
    end

    result_drain u_drain (
        .clk        (clk),
        .rst_n      (rst_n),
        .tile_done  (tile_done),
        .tile_info  (tile_info),
        .acc_grid   (acc_grid),
        .c_wr_en    (c_wr_en),
        .c_index    (c_index),
        .c_data     (c_data),
        .drain_done (drain_done)
    );

endmodule

`default_nettype wire

// File: testbench/tb_tpu_util.svh
`ifndef TB_TPU_UTIL_SVH
`define TB_TPU_UTIL_SVH

// galois lfsr, one step per returned bit
function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < count; i++) begin
        val = {val[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hA300_0000 : 32'h0);
    end
    return val;
endfunction

task automatic check_value(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
    if (actual !== expected) begin
        $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
        err_count++;
    end
endtask

// expected C words rebuilt from the A, B and C word layouts
task automatic check_results(input int k, input int m, input int n);
    int row;
    int col;
    int exp_cnt;
    logic [31:0] sum;
    tpu_data_pkg::c_row_t exp_row;
    for (int idx = 0; idx < 256; idx++) begin
        exp_cnt = (idx < m * ((n + 3) / 4)) ? 1 : 0;  // rows beyond M never written
        check_value($sformatf("c write count at %0d", idx), exp_cnt, c_cnt[idx]);
        if (exp_cnt == 1) begin
            row = idx % m;
            exp_row = '0;
            for (int c = 0; c < 4; c++) begin
                col = (idx / m) * 4 + c;
                sum = '0;
                for (int kk = 0; kk < k && col < n; kk++) begin  // columns beyond N stay zero
                    sum += 32'(a_mem[(row / 4) * k + kk][row % 4]) *
                           32'(b_mem[(col / 4) * k + kk][col % 4]);
                end
                exp_row[c] = sum;
            end
            check_value($sformatf("c_data at %0d", idx), exp_row, c_mem[idx]);
        end
    end
endtask

`endif

// File: testbench/tb_tpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tpu;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    tpu_cfg_pkg::dim_t       k_dim;
    tpu_cfg_pkg::dim_t       m_dim;
    tpu_cfg_pkg::dim_t       n_dim;
    logic                    busy;
    tpu_cfg_pkg::idx_t       a_index;
    tpu_cfg_pkg::idx_t       b_index;
    tpu_cfg_pkg::idx_t       c_index;
    tpu_data_pkg::lane_vec_t a_data;
    tpu_data_pkg::lane_vec_t b_data;
    logic                    c_wr_en;
    tpu_data_pkg::c_row_t    c_data;

    tpu_data_pkg::lane_vec_t a_mem [256];
    tpu_data_pkg::lane_vec_t b_mem [256];
    tpu_data_pkg::c_row_t    c_mem [256];
    int                      c_cnt [256];
    logic [7:0]              a_rd_q;  // index held for the read latency
    logic [7:0]              b_rd_q;
    logic [31:0]             lfsr_state;
    int                      err_count;
    int                      test_count;

    `include "tb_tpu_util.svh"

    tpu_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .k_dim    (k_dim),
        .m_dim    (m_dim),
        .n_dim    (n_dim),
        .busy     (busy),
        .a_index  (a_index),
        .a_data   (a_data),
        .b_index  (b_index),
        .b_data   (b_data),
        .c_wr_en  (c_wr_en),
        .c_index  (c_index),
        .c_data   (c_data)
    );

    always #20 clk = ~clk;

    // index seen on one falling edge returns its word on the next
    always @(negedge clk) begin
        a_rd_q <= a_index[7:0];
        b_rd_q <= b_index[7:0];
        a_data <= a_mem[a_rd_q];
        b_data <= b_mem[b_rd_q];
        if (c_wr_en) begin
            check_value("c_index", '0, c_index[15:8]);
            c_mem[c_index[7:0]] <= c_data;
            c_cnt[c_index[7:0]] <= c_cnt[c_index[7:0]] + 1;
        end
    end

    task automatic fill_operands(input bit full);
        for (int i = 0; i < 256; i++) begin
            a_mem[i] = full ? '1 : rand_bits(32);
            b_mem[i] = full ? '1 : rand_bits(32);
        end
    endtask

    task automatic run_job(input int k, input int m, input int n, input bit poke);
        int cyc;
        logic prev_wr;
        for (int i = 0; i < 256; i++) begin
            c_mem[i] = '0;
            c_cnt[i] = 0;
        end
        @(negedge clk);
        k_dim = k;
        m_dim = m;
        n_dim = n;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        check_value("busy", 1, busy);
        cyc = 0;
        prev_wr = 1'b0;
        while (busy && cyc < 4000) begin
            prev_wr = c_wr_en;
            @(negedge clk);
            if (poke && cyc == 5) begin  // second start in the middle of the job
                in_valid = 1'b1;
                k_dim = 8'd1;
            end else begin
                in_valid = 1'b0;
            end
            cyc++;
        end
        if (busy) begin
            $display("timeout: busy still high after %0d cycles", cyc);
            err_count++;
        end else begin
            check_value("c_wr_en", 1, prev_wr);  // last write on the cycle before busy fell
            check_results(k, m, n);
        end
    endtask

    task automatic close_test(input string name);
        test_count++;
        $display("test %0d %s finished, %0d errors so far", test_count, name, err_count);
    endtask

    initial begin
        int jk;
        int jm;
        int jn;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        k_dim = '0;
        m_dim = '0;
        n_dim = '0;
        a_data = '0;
        b_data = '0;
        lfsr_state = 32'h247c_3f9b;
        err_count = 0;
        test_count = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            check_value("busy", 0, busy);
            check_value("c_wr_en", 0, c_wr_en);
        end
        close_test("reset");

        fill_operands(1'b0);
        run_job(4, 4, 4, 1'b0);
        close_test("single tile");

        fill_operands(1'b0);
        run_job(3, 6, 5, 1'b0);
        close_test("ragged dimensions");

        for (int j = 0; j < 8; j++) begin
            jm = 1 + rand_bits(4) % 12;
            jn = 1 + rand_bits(4) % 12;
            jk = 1 + rand_bits(4);
            fill_operands(j == 2);  // one job with every operand at 255
            run_job(jk, jm, jn, 1'b0);
        end
        close_test("random jobs");

        @(negedge clk);
        k_dim = 8'd4;
        m_dim = 8'd0;
        n_dim = 8'd4;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        check_value("busy", 0, busy);
        fill_operands(1'b0);
        run_job(8, 9, 7, 1'b1);
        close_test("ignored starts");

        $display("%0d tests, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
+incdir+testbench
src/tpu_cfg_pkg.sv
src/tpu_data_pkg.sv
src/pe_cell.sv
src/operand_feeder.sv
src/result_drain.sv
src/tile_sequencer.sv
src/tpu_top.sv
testbench/tb_tpu.sv

// File: Bender.yml
package:
  name: tpu_systolic

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/tpu_cfg_pkg.sv
      - src/tpu_data_pkg.sv
      - src/pe_cell.sv
      - src/operand_feeder.sv
      - src/result_drain.sv
      - src/tile_sequencer.sv
      - src/tpu_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_tpu.sv
